// File: hw/axil_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite target port definitions: single beats only, no IDs,
// no bursts and no user signals
//////////////////////////////////////////////////////////////////////
`default_nettype none

package axil_pkg;

  localparam int AXIL_ADDR_W = 6;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int AXIL_PROT_W = 3;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Shared by AW and AR
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_PROT_W-1:0] prot;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    axil_resp_e             resp;
  } axil_r_t;

endpackage

`default_nettype wire

// File: hw/csr_pkg.sv
//////////////////////////////////////////////////////////////////////
// CSR bus definitions: word addressed, one request in flight at a time
//////////////////////////////////////////////////////////////////////
`default_nettype none

package csr_pkg;

  localparam int CSR_ADDR_W  = 4;
  localparam int CSR_DATA_W  = 32;
  localparam int CSR_STRB_W  = CSR_DATA_W / 8;
  localparam int TIMER_W     = 10;
  localparam int MAX_TIMEOUT = 1000;

  // Register file map
  localparam logic [CSR_ADDR_W-1:0] CSR_SECURE_WORD = 4'd6;
  localparam logic [CSR_ADDR_W-1:0] CSR_ID_WORD     = 4'd7;
  localparam logic [CSR_DATA_W-1:0] CSR_ID_VALUE    = 32'h0c5a_0001;

  typedef struct packed {
    logic                  write;
    logic [CSR_ADDR_W-1:0] addr;
    logic [CSR_DATA_W-1:0] wdata;
    logic [CSR_STRB_W-1:0] wstrb;
    logic                  secure;
    logic                  privileged;
  } csr_req_t;

  typedef struct packed {
    logic [CSR_DATA_W-1:0] rdata;
    logic                  slverr;
    logic                  decerr;
  } csr_resp_t;

  typedef enum logic [2:0] {IDLE, ISSUE, WAIT, ABORT_WAIT, RESPOND} bridge_state_e;

endpackage

`default_nettype wire

// File: hw/axil_req_capture.sv
//////////////////////////////////////////////////////////////////////
// One-deep AW, W and AR slots; a write needs both AW and W held
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module axil_req_capture (
  input  logic                clk,
  input  logic                rst,
  input  logic                awvalid,
  output logic                awready,
  input  axil_pkg::axil_aw_t  aw,
  input  logic                wvalid,
  output logic                wready,
  input  axil_pkg::axil_w_t   w,
  input  logic                arvalid,
  output logic                arready,
  input  axil_pkg::axil_aw_t  ar,
  input  logic                take_wr,
  input  logic                take_rd,
  output logic                wr_ready,
  output logic                rd_ready,
  output csr_pkg::csr_req_t   csr_req
);
  import axil_pkg::*;

  axil_aw_t aw_q;
  axil_aw_t ar_q;
  axil_w_t  w_q;
  logic     aw_full;
  logic     w_full;
  logic     ar_full;
  logic     aw_full_n;
  logic     w_full_n;
  logic     ar_full_n;

  // A slot fills only while its ready is high, so fill and take never overlap
  assign aw_full_n = take_wr ? 1'b0 : (aw_full || (awvalid && awready));
  assign w_full_n  = take_wr ? 1'b0 : (w_full || (wvalid && wready));
  assign ar_full_n = take_rd ? 1'b0 : (ar_full || (arvalid && arready));

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      ar_full <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      aw_q    <= '0;
      w_q     <= '0;
      ar_q    <= '0;
    end else begin
      aw_full <= aw_full_n;
      w_full  <= w_full_n;
      ar_full <= ar_full_n;
      awready <= !aw_full_n;
      wready  <= !w_full_n;
      arready <= !ar_full_n;
      if (awvalid && awready) aw_q <= aw;
      if (wvalid && wready) w_q <= w;
      if (arvalid && arready) ar_q <= ar;
    end
  end

  assign wr_ready = aw_full && w_full;
  assign rd_ready = ar_full;

  // Kind follows the take strobe that the FSM raises with the request
  always_comb begin
    csr_req.write      = take_wr;
    csr_req.addr       = take_wr ? aw_q.addr[AXIL_ADDR_W-1:2] : ar_q.addr[AXIL_ADDR_W-1:2];
    csr_req.wdata      = take_wr ? w_q.data : '0;
    csr_req.wstrb      = take_wr ? w_q.strb : '0;
    csr_req.secure     = take_wr ? !aw_q.prot[1] : !ar_q.prot[1];
    csr_req.privileged = take_wr ? aw_q.prot[0] : ar_q.prot[0];
  end

endmodule

`default_nettype wire

// File: hw/axil_csr_fsm.sv
//////////////////////////////////////////////////////////////////////
// Bridge sequencer: one CSR request at a time, reads and writes
// alternate when both are waiting
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module axil_csr_fsm (
  input  logic clk,
  input  logic rst,
  input  logic wr_ready,
  input  logic rd_ready,
  output logic take_wr,
  output logic take_rd,
  output logic csr_req_valid,
  input  logic csr_resp_valid,
  output logic csr_req_abort,
  output logic request_aborted,
  output logic resp_take,
  output logic resp_is_write,
  input  logic resp_done,
  output logic timer_clear,
  output logic timer_run,
  input  logic expired
);
  import csr_pkg::*;

  bridge_state_e state;
  bridge_state_e state_n;
  // Kind of the access in flight, also the last one served
  logic last_wr;
  logic last_wr_n;

  always_comb begin
    state_n   = state;
    last_wr_n = last_wr;
    case (state)
      IDLE: begin
        if (wr_ready && (!rd_ready || !last_wr)) begin
          state_n   = ISSUE;
          last_wr_n = 1'b1;
        end else if (rd_ready) begin
          state_n   = ISSUE;
          last_wr_n = 1'b0;
        end
      end
      ISSUE: state_n = WAIT;
      WAIT: begin
        if (csr_resp_valid) state_n = RESPOND;
        else if (expired) state_n = ABORT_WAIT;
      end
      ABORT_WAIT: begin
        if (csr_resp_valid || expired) state_n = RESPOND;
      end
      RESPOND: begin
        if (resp_done) state_n = IDLE;
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      last_wr <= 1'b0;
    end else begin
      state   <= state_n;
      last_wr <= last_wr_n;
    end
  end

  // Request is issued and its capture slots released in the same cycle
  assign csr_req_valid = (state == ISSUE);
  assign take_wr       = (state == ISSUE) && last_wr;
  assign take_rd       = (state == ISSUE) && !last_wr;

  // A response in the expiry cycle wins over the timeout
  assign resp_take       = ((state == WAIT) || (state == ABORT_WAIT)) && csr_resp_valid;
  assign csr_req_abort   = (state == WAIT) && expired && !csr_resp_valid;
  assign request_aborted = (state == ABORT_WAIT) && expired && !csr_resp_valid;
  assign resp_is_write   = last_wr;

  // Restart the count on entry to WAIT and to ABORT_WAIT
  assign timer_clear = (state == ISSUE) || csr_req_abort;
  assign timer_run   = (state == WAIT) || (state == ABORT_WAIT);

endmodule

`default_nettype wire

// File: hw/csr_timeout_timer.sv
//////////////////////////////////////////////////////////////////////
// Wait counter for CSR responses; timeout_cycles must be 1..MAX_TIMEOUT
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_timeout_timer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clear,
  input  logic                     run,
  input  logic [csr_pkg::TIMER_W-1:0] timeout_cycles,
  output logic                     expired
);
  import csr_pkg::*;

  // One spare bit so the count can pass any legal limit
  logic [TIMER_W:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (run && (count != '1)) begin
      count <= count + 1'b1;
    end
  end

  // Stays set once the limit is reached, until the next clear
  assign expired = (count >= {1'b0, timeout_cycles});

endmodule

`default_nettype wire

// File: hw/axil_resp_gen.sv
//////////////////////////////////////////////////////////////////////
// B and R holding registers; an aborted access returns SLVERR, data 0
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module axil_resp_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 resp_take,
  input  logic                 request_aborted,
  input  logic                 resp_is_write,
  input  csr_pkg::csr_resp_t   csr_resp,
  output logic                 bvalid,
  input  logic                 bready,
  output axil_pkg::axil_resp_e bresp,
  output logic                 rvalid,
  input  logic                 rready,
  output axil_pkg::axil_r_t    r,
  output logic                 resp_done
);
  import axil_pkg::*;

  axil_resp_e                 code_n;
  logic [AXIL_DATA_W-1:0]     data_n;

  // DECERR has priority over SLVERR
  always_comb begin
    if (request_aborted) code_n = SLVERR;
    else if (csr_resp.decerr) code_n = DECERR;
    else if (csr_resp.slverr) code_n = SLVERR;
    else code_n = OKAY;
    data_n = request_aborted ? '0 : csr_resp.rdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      bresp  <= OKAY;
      r      <= '0;
    end else begin
      if (bvalid && bready) bvalid <= 1'b0;
      if (rvalid && rready) rvalid <= 1'b0;
      // The FSM waits for resp_done, so a held response is never overwritten
      if (resp_take || request_aborted) begin
        if (resp_is_write) begin
          bvalid <= 1'b1;
          bresp  <= code_n;
        end else begin
          rvalid <= 1'b1;
          r      <= '{data: data_n, resp: code_n};
        end
      end
    end
  end

  assign resp_done = (bvalid && bready) || (rvalid && rready);

endmodule

`default_nettype wire

// File: hw/csr_reg_file.sv
//////////////////////////////////////////////////////////////////////
// CSR target: answers one cycle after a request, except words 8..11,
// which never answer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module csr_reg_file (
  input  logic               clk,
  input  logic               rst,
  input  logic               csr_req_valid,
  input  csr_pkg::csr_req_t  csr_req,
  input  logic               csr_req_abort,
  output logic               csr_resp_valid,
  output csr_pkg::csr_resp_t csr_resp
);
  import csr_pkg::*;

  // Words 0..6 are storage, word 7 is the fixed ID
  logic [CSR_DATA_W-1:0] regs [7];
  csr_resp_t             resp_n;
  logic                  wr_en;
  logic                  silent;

  assign silent = (csr_req.addr[3:2] == 2'b10);

  always_comb begin
    resp_n = '0;
    wr_en  = 1'b0;
    if (csr_req.addr[3]) begin
      resp_n.decerr = csr_req.addr[2];
    end else if (csr_req.addr == CSR_ID_WORD) begin
      if (csr_req.write) resp_n.slverr = 1'b1;
      else resp_n.rdata = CSR_ID_VALUE;
    end else if ((csr_req.addr == CSR_SECURE_WORD) && !csr_req.secure) begin
      resp_n.slverr = 1'b1;
    end else if (csr_req.write) begin
      wr_en = 1'b1;
    end else begin
      resp_n.rdata = regs[csr_req.addr[2:0]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 7; i++) regs[i] <= '0;
      csr_resp_valid <= 1'b0;
      csr_resp       <= '0;
    end else begin
      // Aborts only reach the silent window, where nothing is pending
      csr_resp_valid <= csr_req_valid && !silent && !csr_req_abort;
      if (csr_req_valid) begin
        csr_resp <= resp_n;
        if (wr_en) begin
          for (int b = 0; b < CSR_STRB_W; b++) begin
            if (csr_req.wstrb[b]) regs[csr_req.addr[2:0]][8*b +: 8] <= csr_req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/axil_csr_top.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite to CSR bridge with its register file; timeout_cycles must
// be non-zero and at most MAX_TIMEOUT
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module axil_csr_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        awvalid,
  output logic                        awready,
  input  axil_pkg::axil_aw_t          aw,
  input  logic                        wvalid,
  output logic                        wready,
  input  axil_pkg::axil_w_t           w,
  output logic                        bvalid,
  input  logic                        bready,
  output axil_pkg::axil_resp_e        bresp,
  input  logic                        arvalid,
  output logic                        arready,
  input  axil_pkg::axil_aw_t          ar,
  output logic                        rvalid,
  input  logic                        rready,
  output axil_pkg::axil_r_t           r,
  input  logic [csr_pkg::TIMER_W-1:0] timeout_cycles
);
  import csr_pkg::*;

  logic      wr_ready;
  logic      rd_ready;
  logic      take_wr;
  logic      take_rd;
  csr_req_t  csr_req;
  logic      csr_req_valid;
  logic      csr_req_abort;
  logic      csr_resp_valid;
  csr_resp_t csr_resp;
  logic      request_aborted;
  logic      resp_take;
  logic      resp_is_write;
  logic      resp_done;
  logic      timer_clear;
  logic      timer_run;
  logic      expired;

  axil_req_capture u_capture (
    .clk, .rst, .awvalid, .awready, .aw, .wvalid, .wready, .w,
    .arvalid, .arready, .ar, .take_wr, .take_rd, .wr_ready, .rd_ready, .csr_req
  );

  axil_csr_fsm u_fsm (
    .clk, .rst, .wr_ready, .rd_ready, .take_wr, .take_rd, .csr_req_valid,
    .csr_resp_valid, .csr_req_abort, .request_aborted, .resp_take, .resp_is_write,
    .resp_done, .timer_clear, .timer_run, .expired
  );

  csr_timeout_timer u_timer (
    .clk, .rst, .clear(timer_clear), .run(timer_run), .timeout_cycles, .expired
  );

  axil_resp_gen u_resp (
    .clk, .rst, .resp_take, .request_aborted, .resp_is_write, .csr_resp,
    .bvalid, .bready, .bresp, .rvalid, .rready, .r, .resp_done
  );

  csr_reg_file u_regs (
    .clk, .rst, .csr_req_valid, .csr_req, .csr_req_abort, .csr_resp_valid, .csr_resp
  );

endmodule

`default_nettype wire

// File: sim/axil_csr_assertions.sv
//////////////////////////////////////////////////////////////////////
// Request, abort and timeout checks, bound into axil_csr_fsm
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module axil_csr_assertions (
  input logic                   clk,
  input logic                   rst,
  input csr_pkg::bridge_state_e state,
  input logic                   wr_ready,
  input logic                   rd_ready,
  input logic                   take_wr,
  input logic                   take_rd,
  input logic                   csr_req_valid,
  input logic                   csr_req_abort,
  input logic                   request_aborted
);
  import csr_pkg::*;

  logic pending;
  logic abort_sent;

  // A request stays pending from its pulse until the FSM is idle again
  always_ff @(posedge clk) begin
    if (rst) begin
      pending    <= 1'b0;
      abort_sent <= 1'b0;
    end else begin
      if (csr_req_valid) pending <= 1'b1;
      else if (state == IDLE) pending <= 1'b0;
      if (csr_req_valid) abort_sent <= 1'b0;
      else if (csr_req_abort) abort_sent <= 1'b1;
    end
  end

  // The request must consume a slot that the capture block still holds
  req_from_held_slot: assert property (@(posedge clk) disable iff (rst)
    csr_req_valid |-> ((take_wr && wr_ready) || (take_rd && rd_ready)))
    else $error("csr_req_valid raised without a held capture slot");

  single_abort: assert property (@(posedge clk) disable iff (rst)
    csr_req_abort |-> !abort_sent)
    else $error("second abort sent for one request");

  no_req_while_pending: assert property (@(posedge clk) disable iff (rst)
    csr_req_valid |-> !pending)
    else $error("new request issued while one is pending");

  // Second expiry only follows an abort of the same request
  aborted_after_abort: assert property (@(posedge clk) disable iff (rst)
    request_aborted |-> abort_sent)
    else $error("request_aborted pulsed before an abort was sent");

endmodule

`default_nettype wire

// File: sim/tb_axil_csr.sv
//////////////////////////////////////////////////////////////////////
// Bridge testbench; writes and reads strictly alternate so the model
// order matches the order in which the bridge serves them
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_axil_csr;
  import axil_pkg::*;
  import csr_pkg::*;

  localparam logic [31:0]            SEED           = 32'hc44b0392;
  localparam int                     TIMEOUT_CYCLES = 12;
  localparam int                     WAIT_LIMIT     = 200;
  localparam int                     DRAIN_LIMIT    = 2000;
  localparam logic [AXIL_DATA_W-1:0] ID_VALUE       = 32'h0c5a_0001;

  // Expected response plus the earliest cycle it may arrive
  typedef struct packed {
    axil_r_t r;
    int      min_cycle;
  } exp_t;

  logic clk = 1'b0;
  logic rst;
  logic awvalid, awready, wvalid, wready, arvalid, arready;
  logic bvalid, rvalid;
  logic bready = 1'b0;
  logic rready = 1'b0;
  axil_aw_t aw, ar;
  axil_w_t w;
  axil_resp_e bresp;
  axil_r_t r;
  logic [TIMER_W-1:0] timeout_cycles;

  logic [AXIL_DATA_W-1:0] model_regs [8];
  exp_t  b_q[$], r_q[$];
  exp_t  b_exp, r_exp;
  string cur_test;
  int    cycle = 0;
  int    errors = 0;
  int    err_base, tests, failed;
  int    b_sent, r_sent, b_seen, r_seen;

  axil_csr_top dut (.*);

  bind axil_csr_fsm axil_csr_assertions u_checks (
    .clk, .rst, .state, .wr_ready, .rd_ready, .take_wr, .take_rd,
    .csr_req_valid, .csr_req_abort, .request_aborted
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Random back-pressure on B and R
  always @(posedge clk) begin
    bready <= ($urandom % 4) != 0;
    rready <= ($urandom % 4) != 0;
  end

  // Expected result of one access; updates the register model on writes
  function automatic axil_r_t model_access(input logic write, input logic [3:0] word,
                                           input logic [2:0] prot,
                                           input logic [AXIL_DATA_W-1:0] data,
                                           input logic [AXIL_STRB_W-1:0] strb);
    axil_r_t res;
    res.data = '0;
    res.resp = OKAY;
    if (word >= 4'd12) begin
      res.resp = DECERR;
    end else if (word >= 4'd8) begin
      res.resp = SLVERR;
    end else if (word == 4'd7) begin
      if (write) res.resp = SLVERR;
      else res.data = ID_VALUE;
    end else if ((word == 4'd6) && prot[1]) begin
      res.resp = SLVERR;
    end else if (write) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (strb[b]) model_regs[word[2:0]][8*b +: 8] = data[8*b +: 8];
      end
    end else begin
      res.data = model_regs[word[2:0]];
    end
    return res;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout in test %s: %s", cur_test, what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic check_resp(input string label, input axil_resp_e exp, input axil_resp_e act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %s actual %s", label, exp.name(), act.name());
    end
  endtask

  task automatic check_rdata(input string label, input logic [AXIL_DATA_W-1:0] exp,
                             input logic [AXIL_DATA_W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h actual %h", label, exp, act);
    end
  endtask

  task automatic check_latency(input string label, input int min_cycle);
    if (cycle < min_cycle) begin
      errors++;
      $display("ERROR %s: expected cycle >= %0d actual %0d", label, min_cycle, cycle);
    end
  endtask

  // Order 0 sends AW and W together, 1 sends AW first, 2 sends W first
  task automatic axi_write(input logic [3:0] word, input logic [2:0] prot,
                           input logic [AXIL_DATA_W-1:0] data,
                           input logic [AXIL_STRB_W-1:0] strb, input int order);
    exp_t e;
    int   waited;
    bit   aw_done;
    bit   w_done;
    waited  = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    if (order != 2) begin
      awvalid <= 1'b1;
      aw      <= '{addr: {word, 2'b00}, prot: prot};
    end
    if (order != 1) begin
      wvalid <= 1'b1;
      w      <= '{data: data, strb: strb};
    end
    while (!(aw_done && w_done) && (waited < WAIT_LIMIT)) begin
      @(posedge clk);
      waited++;
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
        if (order == 1) begin
          wvalid <= 1'b1;
          w      <= '{data: data, strb: strb};
        end
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
        if (order == 2) begin
          awvalid <= 1'b1;
          aw      <= '{addr: {word, 2'b00}, prot: prot};
        end
      end
    end
    if (!(aw_done && w_done)) begin
      abort_on_timeout("write address or data was never accepted");
    end else begin
      e.r         = model_access(1'b1, word, prot, data, strb);
      e.min_cycle = (word >= 4'd8 && word <= 4'd11) ? cycle + 2 * TIMEOUT_CYCLES : 0;
      b_q.push_back(e);
      b_sent++;
    end
  endtask

  task automatic axi_read(input logic [3:0] word, input logic [2:0] prot);
    exp_t e;
    int   waited;
    waited = 0;
    arvalid <= 1'b1;
    ar      <= '{addr: {word, 2'b00}, prot: prot};
    do begin
      @(posedge clk);
      waited++;
    end while (!(arvalid && arready) && (waited < WAIT_LIMIT));
    if (!(arvalid && arready)) begin
      abort_on_timeout("read address was never accepted");
    end else begin
      arvalid     <= 1'b0;
      e.r         = model_access(1'b0, word, prot, '0, '0);
      e.min_cycle = (word >= 4'd8 && word <= 4'd11) ? cycle + 2 * TIMEOUT_CYCLES : 0;
      r_q.push_back(e);
      r_sent++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = errors;
  endtask

  // Waits until every issued access has been answered
  task automatic end_test();
    int waited;
    waited = 0;
    while (((b_q.size() != 0) || (r_q.size() != 0)) && (waited < DRAIN_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    if ((b_q.size() != 0) || (r_q.size() != 0)) begin
      abort_on_timeout("responses for issued accesses never arrived");
    end else begin
      tests++;
      if (errors != err_base) failed++;
      $display("Test %s %s, %0d errors", cur_test,
               (errors == err_base) ? "passed" : "failed", errors - err_base);
    end
  endtask

  // Compare each B and R handshake with the oldest expectation
  always @(posedge clk) begin
    if (!rst && bvalid && bready) begin
      b_seen++;
      if (b_q.size() == 0) begin
        errors++;
        $display("Write response in test %s arrived with no write outstanding", cur_test);
      end else begin
        b_exp = b_q.pop_front();
        check_resp({cur_test, " bresp"}, b_exp.r.resp, bresp);
        check_latency({cur_test, " write"}, b_exp.min_cycle);
      end
    end
    if (!rst && rvalid && rready) begin
      r_seen++;
      if (r_q.size() == 0) begin
        errors++;
        $display("Read response in test %s arrived with no read outstanding", cur_test);
      end else begin
        r_exp = r_q.pop_front();
        check_resp({cur_test, " rresp"}, r_exp.r.resp, r.resp);
        check_rdata({cur_test, " rdata"}, r_exp.r.data, r.data);
        check_latency({cur_test, " read"}, r_exp.min_cycle);
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    for (int k = 0; k < 8; k++) model_regs[k] = '0;
    rst            <= 1'b1;
    awvalid        <= 1'b0;
    wvalid         <= 1'b0;
    arvalid        <= 1'b0;
    aw             <= '0;
    w              <= '0;
    ar             <= '0;
    timeout_cycles <= TIMER_W'(TIMEOUT_CYCLES);
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    begin_test("rw_words");
    for (int i = 0; i < 12; i++) begin
      axi_write(4'(i % 6), 3'b000, $urandom, 4'($urandom), 0);
      axi_read(4'(i % 6), 3'b001);
    end
    end_test();

    begin_test("secure_word");
    axi_write(4'd6, 3'b000, $urandom, 4'($urandom), 0);
    axi_read(4'd6, 3'b000);
    axi_write(4'd6, 3'b010, $urandom, 4'hf, 0);
    axi_read(4'd6, 3'b000);
    axi_write(4'd6, 3'b001, $urandom, 4'($urandom), 0);
    axi_read(4'd6, 3'b011);
    end_test();

    begin_test("id_word");
    axi_read(4'd7, 3'b000);
    axi_write(4'd7, 3'b000, $urandom, 4'hf, 0);
    axi_read(4'd7, 3'b010);
    end_test();

    begin_test("unmapped");
    for (int i = 12; i < 16; i++) begin
      axi_write(4'(i), 3'b000, $urandom, 4'($urandom), 0);
      axi_read(4'(i), 3'b000);
    end
    end_test();

    // Silent window first, then a normal access behind it
    begin_test("silent_window");
    axi_read(4'd8, 3'b000);
    axi_write(4'd9, 3'b000, $urandom, 4'hf, 0);
    axi_read(4'd10, 3'b000);
    axi_write(4'd11, 3'b000, $urandom, 4'hf, 0);
    axi_read(4'd0, 3'b000);
    axi_write(4'd0, 3'b000, $urandom, 4'($urandom), 0);
    axi_read(4'd0, 3'b000);
    end_test();

    begin_test("mixed_traffic");
    for (int i = 0; i < 24; i++) begin
      axi_write(4'($urandom % 7), 3'($urandom), $urandom, 4'($urandom), int'($urandom % 3));
      axi_read(4'($urandom % 7), 3'($urandom));
    end
    end_test();

    // Quiet tail so a duplicated response would still be seen
    repeat (20) @(posedge clk);
    $display("Summary: %0d tests, %0d failed, %0d writes, %0d reads, %0d errors",
             tests, failed, b_seen, r_seen, errors);
    if ((b_seen != b_sent) || (r_seen != r_sent)) begin
      $display("Response count mismatch: %0d of %0d writes and %0d of %0d reads answered",
               b_seen, b_sent, r_seen, r_sent);
    end
    if ((errors == 0) && (b_seen == b_sent) && (r_seen == r_sent)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hw/axil_pkg.sv
hw/csr_pkg.sv
hw/axil_req_capture.sv
hw/axil_csr_fsm.sv
hw/csr_timeout_timer.sv
hw/axil_resp_gen.sv
hw/csr_reg_file.sv
hw/axil_csr_top.sv
sim/axil_csr_assertions.sv
sim/tb_axil_csr.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI4-Lite to CSR bridge testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_axil_csr -Mdir "$BUILD_DIR" -o Vtb_axil_csr
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_axil_csr" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
